//--- bench/gprf_ref.svh
// Register file reference model
`ifndef GPRF_REF_SVH
`define GPRF_REF_SVH

logic [31:0] shadow [2][32];   // Expected bank contents per thread

// Zero-extended load lane, big endian byte order
function automatic logic [31:0] exp_lane(input logic [3:0] sel, input logic [31:0] dwb,
                                         input logic [31:0] xwb);
   case (sel)
      4'h8:    return {24'h0, dwb[31:24]};
      4'h4:    return {24'h0, dwb[23:16]};
      4'h2:    return {24'h0, dwb[15:8]};
      4'h1:    return {24'h0, dwb[7:0]};
      4'hC:    return {16'h0, dwb[31:16]};
      4'h3:    return {16'h0, dwb[15:0]};
      4'hF:    return dwb;
      4'h0:    return xwb;   // Bus word
      default: return 32'h0;
   endcase
endfunction

// Result word for a source code
function automatic logic [31:0] exp_result(input logic [2:0] code, input logic [3:0] sel,
                                           input logic [31:0] src [7]);
   case (code)
      3'd7:    return src[0];   // ALU
      3'd3:    return src[1];
      3'd4:    return src[2];
      3'd5:    return src[3];
      3'd2:    return exp_lane(sel, src[4], src[5]);
      3'd1:    return {src[6][31:2], 2'b00};   // Link, word aligned
      default: return 32'h0;
   endcase
endfunction

// Write rule, R0 and nop never written
task automatic model_write(input logic thr, input logic [4:0] rd, input logic [2:0] code,
                           input logic [3:0] sel, input logic [31:0] src [7]);
   if (rd != 5'd0 && code != 3'd0)
      shadow[thr][rd] = exp_result(code, sel, src);
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
   if (act !== exp) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      row_err++;
   end
endtask

`endif

//--- bench/gprf_tb.sv
// Register file testbench
`timescale 1ns/1ps

module gprf_tb
   import gprf_pkg::*;
;

   localparam int max_rows = 32;
   localparam int wait_limit = 50;   // Cycles before a wait gives up

   logic        gclk;
   logic        grst;
   logic        dena;
   logic        gpha;
   logic [31:0] ich_dat;
   logic [4:0]  rd_ex;
   logic [2:0]  mux_ex;
   logic [3:0]  sel_mx;
   logic [29:0] rpc_mx;
   logic [31:0] alu_mx;
   logic [31:0] mul_mx;
   logic [31:0] bsf_mx;
   logic [31:0] sfr_mx;
   logic [31:0] dwb_mx;
   logic [31:0] xwb_mx;
   logic [31:0] opa_ex;
   logic [31:0] opb_ex;
   logic [31:0] opd_ex;

   // Stimulus table
   logic        t_thr   [max_rows];
   logic [4:0]  t_rd    [max_rows];
   logic [2:0]  t_mux   [max_rows];
   logic [3:0]  t_sel   [max_rows];
   int          t_stall [max_rows];   // Cycles of dena low before the write
   logic [4:0]  t_ra    [max_rows];
   logic [4:0]  t_rb    [max_rows];
   logic [4:0]  t_rdd   [max_rows];
   logic        t_immf  [max_rows];
   logic [15:0] t_imm   [max_rows];
   logic [31:0] t_src   [max_rows][7];   // alu mul bsf sfr dwb xwb rpc
   logic [31:0] t_exp_a [max_rows];
   logic [31:0] t_exp_b [max_rows];
   logic [31:0] t_exp_d [max_rows];

   int     n_rows;
   int     row_err;
   int     err_count;
   int     pass_count;
   logic   timed_out;
   integer seed;

   `include "gprf_ref.svh"

   gprf_top #(
      .data_w   (32),
      .thread_n (2)
   ) dut0 (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .gpha    (gpha),
      .ich_dat (ich_dat),
      .rd_ex   (rd_ex),
      .mux_ex  (mux_ex),
      .sel_mx  (sel_mx),
      .rpc_mx  (rpc_mx),
      .alu_mx  (alu_mx),
      .mul_mx  (mul_mx),
      .bsf_mx  (bsf_mx),
      .sfr_mx  (sfr_mx),
      .dwb_mx  (dwb_mx),
      .xwb_mx  (xwb_mx),
      .opa_ex  (opa_ex),
      .opb_ex  (opb_ex),
      .opd_ex  (opd_ex)
   );

   initial gclk = 1'b0;
   always #5 gclk = ~gclk;   // 10 ns period

   task automatic add_row(input logic thr, input logic [4:0] rd, input logic [2:0] code,
                          input logic [3:0] sel, input int stall, input logic [4:0] ra,
                          input logic [4:0] rb, input logic [4:0] rdd, input logic immf,
                          input logic [15:0] imm);
      t_thr[n_rows]   = thr;
      t_rd[n_rows]    = rd;
      t_mux[n_rows]   = code;
      t_sel[n_rows]   = sel;
      t_stall[n_rows] = stall;
      t_ra[n_rows]    = ra;
      t_rb[n_rows]    = rb;
      t_rdd[n_rows]   = rdd;
      t_immf[n_rows]  = immf;
      t_imm[n_rows]   = imm;
      for (int s = 0; s < 7; s++)
         t_src[n_rows][s] = $random(seed);
      n_rows++;
   endtask

   task automatic build_table();
      n_rows = 0;
      add_row(0, 0, mux_alu, ln_bus, 0, 0, 0, 0, 0, 0);   // R0 stays zero
      add_row(1, 0, mux_mul, ln_bus, 0, 0, 0, 0, 0, 0);
      add_row(0, 5, mux_alu, ln_bus, 0, 5, 0, 5, 0, 0);
      add_row(1, 5, mux_mul, ln_bus, 0, 5, 5, 0, 0, 0);
      add_row(0, 6, mux_bsf, ln_bus, 0, 6, 0, 5, 0, 0);   // t0 R5 kept
      add_row(1, 7, mux_sfr, ln_bus, 0, 7, 5, 7, 0, 0);
      add_row(0, 8, mux_rpc, ln_bus, 0, 8, 8, 6, 0, 0);
      add_row(1, 9, mux_mem, ln_b3, 0, 9, 5, 0, 0, 0);    // Lane sweep
      add_row(0, 10, mux_mem, ln_b2, 0, 10, 5, 0, 0, 0);
      add_row(1, 11, mux_mem, ln_b1, 0, 11, 5, 0, 0, 0);
      add_row(0, 12, mux_mem, ln_b0, 0, 12, 5, 0, 0, 0);
      add_row(1, 13, mux_mem, ln_h1, 0, 13, 5, 0, 0, 0);
      add_row(0, 14, mux_mem, ln_h0, 0, 14, 5, 0, 0, 0);
      add_row(1, 15, mux_mem, ln_word, 0, 15, 5, 0, 0, 0);
      add_row(0, 16, mux_mem, ln_bus, 0, 16, 5, 0, 0, 0);
      add_row(1, 17, mux_mem, 4'h5, 0, 17, 5, 0, 0, 0);   // Undefined lane
      add_row(0, 5, mux_nop, ln_bus, 0, 5, 6, 0, 0, 0);   // Nop leaves R5
      add_row(0, 6, 3'd6, ln_bus, 0, 6, 5, 6, 0, 0);      // Free code writes zero
      add_row(1, 18, mux_alu, ln_bus, 0, 18, 0, 5, 1, 16'h8001);
      add_row(0, 19, mux_alu, ln_bus, 0, 19, 0, 5, 1, 16'h1234);
      add_row(1, 20, mux_alu, ln_bus, 3, 20, 5, 7, 0, 0);  // Stall row
   endtask

   // Next rising edge with dena high
   task automatic wait_enabled_edge();
      int  n;
      logic seen;
      n = 0;
      seen = 1'b0;
      while (!seen && n < wait_limit) begin
         @(posedge gclk);
         seen = dena;
         n++;
      end
      if (!seen) begin
         $display("Timeout, no enabled clock edge within %0d cycles", wait_limit);
         timed_out = 1'b1;
      end
   endtask

   task automatic apply_row(input int k);
      logic [31:0] prev_a;
      logic [31:0] prev_b;
      logic [31:0] prev_d;
      instr_word_u iw;
      row_err = 0;
      // Read word of this row
      iw = '0;
      iw.r.opcode = t_immf[k] ? 6'b001000 : 6'b000000;
      iw.r.rd = t_rdd[k];
      iw.r.ra = t_ra[k];
      if (t_immf[k])
         iw.i.imm = t_imm[k];
      else
         iw.r.rb = t_rb[k];
      // Write phase, bank writes the out-of-phase thread
      gpha   = ~t_thr[k];
      rd_ex  = t_rd[k];
      mux_ex = t_mux[k];
      sel_mx = t_sel[k];
      alu_mx = t_src[k][0];
      mul_mx = t_src[k][1];
      bsf_mx = t_src[k][2];
      sfr_mx = t_src[k][3];
      dwb_mx = t_src[k][4];
      xwb_mx = t_src[k][5];
      rpc_mx = t_src[k][6][31:2];
      dena   = (t_stall[k] == 0);
      if (t_stall[k] > 0) begin
         prev_a = opa_ex;
         prev_b = opb_ex;
         prev_d = opd_ex;
         ich_dat = iw;   // Bank reads change under the frozen stage
         for (int c = 0; c < t_stall[k]; c++) begin
            @(posedge gclk);
            #1;
         end
         check_word("opa_ex stalled", prev_a, opa_ex);
         check_word("opb_ex stalled", prev_b, opb_ex);
         check_word("opd_ex stalled", prev_d, opd_ex);
         dena = 1'b1;   // Resume
      end
      wait_enabled_edge();
      if (timed_out)
         return;
      #1;
      rd_ex  = 5'd0;   // Bubble behind the write
      mux_ex = 3'd0;
      wait_enabled_edge();
      if (timed_out)
         return;
      #1;
      model_write(t_thr[k], t_rd[k], t_mux[k], t_sel[k], t_src[k]);
      // Read phase
      gpha    = t_thr[k];
      ich_dat = iw;
      t_exp_a[k] = shadow[t_thr[k]][t_ra[k]];
      t_exp_b[k] = t_immf[k] ? {{16{t_imm[k][15]}}, t_imm[k]} : shadow[t_thr[k]][t_rb[k]];
      t_exp_d[k] = shadow[t_thr[k]][t_rdd[k]];
      wait_enabled_edge();
      if (timed_out)
         return;
      #1;
      check_word("opa_ex", t_exp_a[k], opa_ex);
      check_word("opb_ex", t_exp_b[k], opb_ex);
      check_word("opd_ex", t_exp_d[k], opd_ex);
      if (row_err == 0) begin
         $display("PASS row %0d", k);
         pass_count++;
      end else begin
         $display("FAIL row %0d with %0d mismatches", k, row_err);
         err_count++;
      end
   endtask

   initial begin
      seed       = 32'hc7da;
      err_count  = 0;
      pass_count = 0;
      timed_out  = 1'b0;
      grst    = 1'b1;
      dena    = 1'b1;
      gpha    = 1'b0;
      ich_dat = '0;
      rd_ex   = '0;
      mux_ex  = '0;
      sel_mx  = '0;
      rpc_mx  = '0;
      alu_mx  = '0;
      mul_mx  = '0;
      bsf_mx  = '0;
      sfr_mx  = '0;
      dwb_mx  = '0;
      xwb_mx  = '0;
      build_table();
      repeat (10) begin   // Phase toggles so both R0s clear
         @(posedge gclk);
         #1;
         gpha = ~gpha;
      end
      grst = 1'b0;
      shadow[0][0] = 32'h0;
      shadow[1][0] = 32'h0;
      for (int k = 0; k < n_rows && !timed_out; k++)
         apply_row(k);
      $display("Rows %0d, passed %0d, failed %0d", n_rows, pass_count, err_count);
      if (err_count == 0 && !timed_out)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- logic/gprf_bank.sv
// Two-thread register bank
`timescale 1ns/1ps

module gprf_bank
   import gprf_pkg::*;
#(
   parameter int data_w   = 32,
   parameter int thread_n = 2
) (
   input  logic                  gclk,
   input  logic                  grst,
   input  logic                  dena,
   input  logic                  gpha,     // Thread in phase, reads
   input  logic [reg_addr_w-1:0] ra_idx,
   input  logic [reg_addr_w-1:0] rb_idx,
   input  logic [reg_addr_w-1:0] rd_idx,
   input  logic [reg_addr_w-1:0] rd_mx,    // Write-back destination
   input  logic                  wrb_en,
   input  logic [data_w-1:0]     wb_dat,
   output logic [data_w-1:0]     rda,
   output logic [data_w-1:0]     rdb,
   output logic [data_w-1:0]     rdd
);

   localparam int depth  = thread_n * (1 << reg_addr_w);
   localparam int addr_w = $clog2(depth);

   // One copy per read port, identical contents
   logic [data_w-1:0] mem_a [depth];
   logic [data_w-1:0] mem_b [depth];
   logic [data_w-1:0] mem_d [depth];

   logic [addr_w-1:0]     ra_addr;
   logic [addr_w-1:0]     rb_addr;
   logic [addr_w-1:0]     rd_addr;
   logic [addr_w-1:0]     wr_addr;
   logic [reg_addr_w-1:0] wr_idx;
   logic                  wr_go;

   // Thread bit on top of the register index
   assign ra_addr = {gpha, ra_idx};
   assign rb_addr = {gpha, rb_idx};
   assign rd_addr = {gpha, rd_idx};

   // Write side belongs to the thread out of phase
   assign wr_idx  = grst ? '0 : rd_mx;   // Reset targets R0
   assign wr_addr = {~gpha, wr_idx};
   assign wr_go   = grst | (dena & wrb_en);

   // Asynchronous reads
   assign rda = mem_a[ra_addr];
   assign rdb = mem_b[rb_addr];
   assign rdd = mem_d[rd_addr];

   // Single write port, fans out to all three copies
   always_ff @(posedge gclk) begin
      if (wr_go) begin
         mem_a[wr_addr] <= wb_dat;   // Zero while reset holds
         mem_b[wr_addr] <= wb_dat;
         mem_d[wr_addr] <= wb_dat;
      end
   end

endmodule

//--- logic/gprf_pkg.sv
// Register file shared definitions
package gprf_pkg;

   localparam int reg_addr_w = 5;   // R0..R31 per thread

   // Write-back source select, code 6 left free
   typedef enum logic [2:0] {
      mux_nop = 3'd0,   // No write
      mux_rpc = 3'd1,   // Link address
      mux_mem = 3'd2,   // Load data or bus word
      mux_mul = 3'd3,
      mux_bsf = 3'd4,   // Barrel shifter
      mux_sfr = 3'd5,   // Special function regs
      mux_alu = 3'd7
   } mux_code_t;

   // Load lane select, one bit per byte lane
   localparam logic [3:0] ln_bus  = 4'h0;   // External bus word
   localparam logic [3:0] ln_b3   = 4'h8;
   localparam logic [3:0] ln_b2   = 4'h4;
   localparam logic [3:0] ln_b1   = 4'h2;
   localparam logic [3:0] ln_b0   = 4'h1;
   localparam logic [3:0] ln_h1   = 4'hC;   // Upper half
   localparam logic [3:0] ln_h0   = 4'h3;   // Lower half
   localparam logic [3:0] ln_word = 4'hF;

   localparam int opc_imm_bit = 3;   // Opcode bit, set for immediate form

   typedef struct packed {
      logic [5:0]            opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] ra;
      logic [reg_addr_w-1:0] rb;
      logic [10:0]           func;
   } instr_reg_t;

   typedef struct packed {
      logic [5:0]            opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] ra;
      logic [15:0]           imm;
   } instr_imm_t;

   // Same fetched word, two field layouts
   typedef union packed {
      instr_reg_t r;
      instr_imm_t i;
   } instr_word_u;

endpackage

//--- logic/gprf_top.sv
// Register file operand and write-back top
`timescale 1ns/1ps

module gprf_top
   import gprf_pkg::*;
#(
   parameter int data_w   = 32,
   parameter int thread_n = 2
) (
   input  logic                  gclk,
   input  logic                  grst,
   input  logic                  dena,
   input  logic                  gpha,
   input  logic [31:0]           ich_dat,
   input  logic [reg_addr_w-1:0] rd_ex,
   input  logic [2:0]            mux_ex,
   input  logic [3:0]            sel_mx,
   input  logic [data_w-1:2]     rpc_mx,
   input  logic [data_w-1:0]     alu_mx,
   input  logic [data_w-1:0]     mul_mx,
   input  logic [data_w-1:0]     bsf_mx,
   input  logic [data_w-1:0]     sfr_mx,
   input  logic [data_w-1:0]     dwb_mx,
   input  logic [data_w-1:0]     xwb_mx,
   output logic [data_w-1:0]     opa_ex,
   output logic [data_w-1:0]     opb_ex,
   output logic [data_w-1:0]     opd_ex
);

   logic [reg_addr_w-1:0] ra_idx;
   logic [reg_addr_w-1:0] rb_idx;
   logic [reg_addr_w-1:0] rd_idx;
   logic [reg_addr_w-1:0] rd_mx;
   logic [data_w-1:0]     rda;
   logic [data_w-1:0]     rdb;
   logic [data_w-1:0]     rdd;
   logic [data_w-1:0]     wb_dat;
   logic                  wrb_en;

   operand_fetch #(
      .data_w (data_w)
   ) u_fetch (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .ich_dat (instr_word_u'(ich_dat)),
      .rda     (rda),
      .rdb     (rdb),
      .rdd     (rdd),
      .ra_idx  (ra_idx),
      .rb_idx  (rb_idx),
      .rd_idx  (rd_idx),
      .opa_ex  (opa_ex),
      .opb_ex  (opb_ex),
      .opd_ex  (opd_ex)
   );

   gprf_bank #(
      .data_w   (data_w),
      .thread_n (thread_n)
   ) u_bank (
      .gclk   (gclk),
      .grst   (grst),
      .dena   (dena),
      .gpha   (gpha),
      .ra_idx (ra_idx),
      .rb_idx (rb_idx),
      .rd_idx (rd_idx),
      .rd_mx  (rd_mx),
      .wrb_en (wrb_en),
      .wb_dat (wb_dat),
      .rda    (rda),
      .rdb    (rdb),
      .rdd    (rdd)
   );

   wb_select #(
      .data_w (data_w)
   ) u_wb (
      .gclk   (gclk),
      .grst   (grst),
      .dena   (dena),
      .rd_ex  (rd_ex),
      .mux_ex (mux_code_t'(mux_ex)),   // Code 6 passes through unnamed
      .alu_mx (alu_mx),
      .mul_mx (mul_mx),
      .bsf_mx (bsf_mx),
      .sfr_mx (sfr_mx),
      .dwb_mx (dwb_mx),
      .xwb_mx (xwb_mx),
      .rpc_mx (rpc_mx),
      .sel_mx (sel_mx),
      .rd_mx  (rd_mx),
      .wrb_en (wrb_en),
      .wb_dat (wb_dat)
   );

endmodule

//--- logic/load_sizer.sv
// Load data lane sizer
`timescale 1ns/1ps

module load_sizer
   import gprf_pkg::*;
#(
   parameter int data_w = 32
) (
   input  logic [3:0]        sel_mx,   // Lane code from memory stage
   input  logic [data_w-1:0] dwb_mx,   // Data bus read word
   input  logic [data_w-1:0] xwb_mx,   // External bus word
   output logic [data_w-1:0] mem_dat
);

   // Lanes are big endian, b3 is the top byte
   always_comb begin
      case (sel_mx)
         // Single bytes, zero extended
         ln_b3:   mem_dat = data_w'(dwb_mx[31:24]);
         ln_b2:   mem_dat = data_w'(dwb_mx[23:16]);
         ln_b1:   mem_dat = data_w'(dwb_mx[15:8]);
         ln_b0:   mem_dat = data_w'(dwb_mx[7:0]);

         // Half words
         ln_h1:   mem_dat = data_w'(dwb_mx[31:16]);
         ln_h0:   mem_dat = data_w'(dwb_mx[15:0]);

         ln_word: mem_dat = dwb_mx;   // Full word as is
         ln_bus:  mem_dat = xwb_mx;   // No lane strobes, take bus word

         // Mixed strobes carry no defined load
         default: mem_dat = '0;
      endcase
   end

endmodule

//--- logic/operand_fetch.sv
// Operand fetch and execute registers
`timescale 1ns/1ps

module operand_fetch
   import gprf_pkg::*;
#(
   parameter int data_w = 32
) (
   input  logic                  gclk,
   input  logic                  grst,
   input  logic                  dena,
   input  instr_word_u           ich_dat,   // Fetched instruction
   input  logic [data_w-1:0]     rda,       // Bank read data
   input  logic [data_w-1:0]     rdb,
   input  logic [data_w-1:0]     rdd,
   output logic [reg_addr_w-1:0] ra_idx,
   output logic [reg_addr_w-1:0] rb_idx,
   output logic [reg_addr_w-1:0] rd_idx,
   output logic [data_w-1:0]     opa_ex,
   output logic [data_w-1:0]     opb_ex,
   output logic [data_w-1:0]     opd_ex
);

   logic              imm_form;   // Immediate form decode
   logic [data_w-1:0] imm_ext;    // Sign extended immediate
   logic [data_w-1:0] opb_sel;

   // rd and ra sit at the same place in both forms
   assign rd_idx = ich_dat.r.rd;
   assign ra_idx = ich_dat.r.ra;
   assign rb_idx = ich_dat.r.rb;   // Meaningless in immediate form

   assign imm_form = ich_dat.i.opcode[opc_imm_bit];
   assign imm_ext  = {{(data_w-16){ich_dat.i.imm[15]}}, ich_dat.i.imm};

   // Operand B source
   assign opb_sel = imm_form ? imm_ext : rdb;

   // Execute stage operands
   always_ff @(posedge gclk) begin
      if (grst) begin
         opa_ex <= '0;
         opb_ex <= '0;
         opd_ex <= '0;
      end else if (dena) begin
         opa_ex <= rda;
         opb_ex <= opb_sel;
         opd_ex <= rdd;   // Store data or third source
      end
   end

endmodule

//--- logic/wb_select.sv
// Write-back stage select
`timescale 1ns/1ps

module wb_select
   import gprf_pkg::*;
#(
   parameter int data_w = 32
) (
   input  logic                  gclk,
   input  logic                  grst,
   input  logic                  dena,     // Pipeline advance
   input  logic [reg_addr_w-1:0] rd_ex,    // Destination in execute
   input  mux_code_t             mux_ex,   // Result source in execute
   input  logic [data_w-1:0]     alu_mx,
   input  logic [data_w-1:0]     mul_mx,
   input  logic [data_w-1:0]     bsf_mx,
   input  logic [data_w-1:0]     sfr_mx,
   input  logic [data_w-1:0]     dwb_mx,
   input  logic [data_w-1:0]     xwb_mx,
   input  logic [data_w-1:2]     rpc_mx,   // Word aligned link address
   input  logic [3:0]            sel_mx,
   output logic [reg_addr_w-1:0] rd_mx,
   output logic                  wrb_en,   // Bank write enable
   output logic [data_w-1:0]     wb_dat
);

   mux_code_t         mux_mx;    // Registered source code
   logic [data_w-1:0] mem_dat;   // Sized load data

   // Stage registers, frozen while dena is low
   always_ff @(posedge gclk) begin
      if (grst) begin
         rd_mx  <= '0;
         mux_mx <= mux_nop;
         wrb_en <= 1'b0;
      end else if (dena) begin
         rd_mx  <= rd_ex;
         mux_mx <= mux_ex;
         wrb_en <= (rd_ex != '0) && (mux_ex != mux_nop);   // R0 never written
      end
   end

   load_sizer #(
      .data_w (data_w)
   ) u_sizer (
      .sel_mx  (sel_mx),
      .dwb_mx  (dwb_mx),
      .xwb_mx  (xwb_mx),
      .mem_dat (mem_dat)
   );

   // Result source
   always_comb begin
      case (mux_mx)
         mux_alu: wb_dat = alu_mx;
         mux_rpc: wb_dat = {rpc_mx, 2'b00};   // Low bits forced clear
         mux_mem: wb_dat = mem_dat;
         mux_mul: wb_dat = mul_mx;
         mux_bsf: wb_dat = bsf_mx;
         mux_sfr: wb_dat = sfr_mx;
         default: wb_dat = '0;   // Nop and the free code
      endcase
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f sim.f --top-module gprf_tb -o gprf_sim

./obj_dir/gprf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
   exit 0
else
   echo "Simulation reported failures, see sim.log"
   exit 1
fi

//--- sim.f
logic/gprf_pkg.sv
logic/load_sizer.sv
logic/wb_select.sv
logic/gprf_bank.sv
logic/operand_fetch.sv
logic/gprf_top.sv
+incdir+bench
bench/gprf_tb.sv
